/* hw/axi_bridge_pkg.sv */
package axi_bridge_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  localparam logic [3:0] AXI_LEN_SINGLE = 4'd0;    // len field is beats minus one
  localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;  // 4 bytes per beat
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  localparam logic [ID_W-1:0] ID_DATA = 4'd0;      // data reader
  localparam logic [ID_W-1:0] ID_INST = 4'd1;      // instruction reader

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;  // bit n enables byte lane n

  typedef struct packed {
    addr_t      addr;
    logic [3:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ar_t;

  typedef struct packed {
    logic [ID_W-1:0] id;  // source tag added by the arbiter
    addr_t           addr;
    logic [3:0]      len;
    logic [2:0]      size;
    logic [1:0]      burst;
  } axi_ar_bus_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    data_t           data;
    logic [1:0]      resp;
    logic            last;
  } axi_r_t;

  typedef axi_ar_t axi_aw_t;  // same fields on the write address channel

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_SEND, WR_RESP} wr_state_e;

endpackage

/* hw/axi_read_adapter.sv */
`timescale 1ns/1ps

module axi_read_adapter
  import axi_bridge_pkg::*;
(
  input  logic    aclk,
  input  logic    rst_i,
  input  logic    flush_i,
  input  logic    req_i,
  input  addr_t   addr_i,
  output logic    addr_ok_o,
  output logic    data_ok_o,
  output data_t   rdata_o,
  output addr_t   data_addr_o,
  output logic    ar_valid_o,
  output axi_ar_t ar_o,
  input  logic    ar_ready_i,
  input  logic    r_valid_i,
  input  axi_r_t  r_i,
  output logic    r_ready_o
);

  rd_state_e state_q;
  addr_t     addr_q;
  data_t     rdata_q;
  logic      discard_q;  // read was flushed, drop its data
  logic      data_ok_q;
  logic      ar_fire;
  logic      r_fire;

  assign ar_valid_o = (state_q == RD_ADDR);
  assign r_ready_o  = (state_q == RD_DATA);
  assign ar_fire    = ar_valid_o & ar_ready_i;
  assign r_fire     = r_ready_o & r_valid_i;

  assign ar_o.addr  = addr_q;
  assign ar_o.len   = AXI_LEN_SINGLE;
  assign ar_o.size  = AXI_SIZE_WORD;
  assign ar_o.burst = AXI_BURST_INCR;

  assign addr_ok_o   = ar_fire;    // request accepted on the AR handshake
  assign data_ok_o   = data_ok_q;
  assign rdata_o     = rdata_q;
  assign data_addr_o = addr_q;     // still holds the address in the data_ok cycle

  always_ff @(posedge aclk) begin
    if (rst_i) begin
      state_q   <= RD_IDLE;
      discard_q <= 1'b0;
      data_ok_q <= 1'b0;
    end else begin
      data_ok_q <= 1'b0;
      case (state_q)
        RD_IDLE: begin
          if (req_i) begin
            state_q   <= RD_ADDR;
            discard_q <= 1'b0;
          end
        end
        RD_ADDR: begin
          if (flush_i) discard_q <= 1'b1;
          if (ar_fire) state_q <= RD_DATA;
        end
        RD_DATA: begin
          if (flush_i) discard_q <= 1'b1;
          if (r_fire) begin
            data_ok_q <= ~(discard_q | flush_i);  // flushed reads finish silently
            state_q   <= RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state_q == RD_IDLE && req_i) addr_q <= addr_i;
    if (r_fire) rdata_q <= r_i.data;
  end

endmodule

/* hw/axi_write_adapter.sv */
`timescale 1ns/1ps

module axi_write_adapter
  import axi_bridge_pkg::*;
(
  input  logic    aclk,
  input  logic    rst_i,
  input  logic    req_i,
  input  addr_t   addr_i,
  input  data_t   wdata_i,
  input  strb_t   sel_i,
  output logic    done_o,
  output logic    aw_valid_o,
  output axi_aw_t aw_o,
  input  logic    aw_ready_i,
  output logic    w_valid_o,
  output axi_w_t  w_o,
  input  logic    w_ready_i,
  input  logic    b_valid_i,
  input  axi_b_t  b_i,
  output logic    b_ready_o
);

  wr_state_e state_q;
  addr_t     addr_q;
  data_t     wdata_q;
  strb_t     sel_q;
  logic      aw_done_q;  // AW already handed over
  logic      w_done_q;   // W already handed over
  logic      done_q;
  logic      accept;
  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;

  // req_i is still high while done_o pulses, so it must not start a second write
  assign accept  = (state_q == WR_IDLE) & req_i & ~done_q;

  assign aw_valid_o = (state_q == WR_SEND) & ~aw_done_q;
  assign w_valid_o  = (state_q == WR_SEND) & ~w_done_q;
  assign b_ready_o  = (state_q == WR_RESP);
  assign aw_fire    = aw_valid_o & aw_ready_i;
  assign w_fire     = w_valid_o & w_ready_i;
  assign b_fire     = b_ready_o & b_valid_i;

  assign aw_o.addr  = addr_q;
  assign aw_o.len   = AXI_LEN_SINGLE;
  assign aw_o.size  = AXI_SIZE_WORD;
  assign aw_o.burst = AXI_BURST_INCR;
  assign w_o.data   = wdata_q;
  assign w_o.strb   = sel_q;
  assign w_o.last   = 1'b1;  // single beat

  assign done_o = done_q;

  always_ff @(posedge aclk) begin
    if (rst_i) begin
      state_q   <= WR_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        WR_IDLE: begin
          if (accept) begin
            state_q   <= WR_SEND;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
        end
        WR_SEND: begin
          if (aw_fire) aw_done_q <= 1'b1;
          if (w_fire) w_done_q <= 1'b1;
          if ((aw_done_q | aw_fire) && (w_done_q | w_fire)) state_q <= WR_RESP;
        end
        WR_RESP: begin
          if (b_fire) begin
            done_q  <= 1'b1;  // response code is not reported to the core
            state_q <= WR_IDLE;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      sel_q   <= sel_i;
    end
  end

endmodule

/* hw/axi_read_arbiter.sv */
`timescale 1ns/1ps

module axi_read_arbiter
  import axi_bridge_pkg::*;
(
  input  logic        aclk,
  input  logic        rst_i,
  input  logic        data_ar_valid_i,
  input  axi_ar_t     data_ar_i,
  output logic        data_ar_ready_o,
  input  logic        inst_ar_valid_i,
  input  axi_ar_t     inst_ar_i,
  output logic        inst_ar_ready_o,
  output logic        data_r_valid_o,
  input  logic        data_r_ready_i,
  output logic        inst_r_valid_o,
  input  logic        inst_r_ready_i,
  output logic        ar_valid_o,
  output axi_ar_bus_t ar_o,
  input  logic        ar_ready_i,
  input  logic        r_valid_i,
  input  axi_r_t      r_i,
  output logic        r_ready_o
);

  logic    grant_inst_q;  // last cycle's winner
  logic    lock_q;        // AR was stalled last cycle, keep the winner
  logic    sel_inst;
  logic    rid_inst;
  axi_ar_t ar_sel;

  // data reader has fixed priority unless a stalled grant must be kept
  assign sel_inst = lock_q ? grant_inst_q : ~data_ar_valid_i;
  assign ar_sel   = sel_inst ? inst_ar_i : data_ar_i;

  assign ar_valid_o = sel_inst ? inst_ar_valid_i : data_ar_valid_i;
  assign ar_o.id    = sel_inst ? ID_INST : ID_DATA;
  assign ar_o.addr  = ar_sel.addr;
  assign ar_o.len   = ar_sel.len;
  assign ar_o.size  = ar_sel.size;
  assign ar_o.burst = ar_sel.burst;

  assign data_ar_ready_o = ~sel_inst & ar_ready_i;
  assign inst_ar_ready_o = sel_inst & ar_ready_i;

  // R beats go back to whichever reader owns the ID
  assign rid_inst       = (r_i.id == ID_INST);
  assign data_r_valid_o = r_valid_i & (r_i.id == ID_DATA);
  assign inst_r_valid_o = r_valid_i & rid_inst;
  assign r_ready_o      = rid_inst ? inst_r_ready_i : data_r_ready_i;

  always_ff @(posedge aclk) begin
    if (rst_i) begin
      grant_inst_q <= 1'b0;
      lock_q       <= 1'b0;
    end else begin
      grant_inst_q <= sel_inst;
      lock_q       <= ar_valid_o & ~ar_ready_i;
    end
  end

endmodule

/* hw/cpu_axi_bridge.sv */
`timescale 1ns/1ps

module cpu_axi_bridge
  import axi_bridge_pkg::*;
(
  input  logic        aclk,
  input  logic        rst_i,
  input  logic        flush_i,
  input  logic        inst_req_i,
  input  addr_t       inst_addr_i,
  output logic        inst_addr_ok_o,
  output logic        inst_data_ok_o,
  output data_t       inst_rdata_o,
  output addr_t       inst_data_addr_o,
  input  logic        data_req_i,
  input  logic        data_wr_i,
  input  strb_t       data_sel_i,
  input  addr_t       data_addr_i,
  input  data_t       data_wdata_i,
  output logic        data_addr_ok_o,
  output logic        data_data_ok_o,
  output data_t       data_rdata_o,
  output logic        ar_valid_o,
  output axi_ar_bus_t ar_o,
  input  logic        ar_ready_i,
  input  logic        r_valid_i,
  input  axi_r_t      r_i,
  output logic        r_ready_o,
  output logic        aw_valid_o,
  output axi_aw_t     aw_o,
  input  logic        aw_ready_i,
  output logic        w_valid_o,
  output axi_w_t      w_o,
  input  logic        w_ready_i,
  input  logic        b_valid_i,
  input  axi_b_t      b_i,
  output logic        b_ready_o
);

  logic    inst_ar_valid, inst_ar_ready, inst_r_valid, inst_r_ready;
  logic    data_ar_valid, data_ar_ready, data_r_valid, data_r_ready;
  axi_ar_t inst_ar;
  axi_ar_t data_ar;
  logic    rd_addr_ok, rd_data_ok, wr_done;

  axi_read_adapter u_inst_rd (
    .aclk, .rst_i, .flush_i,
    .req_i(inst_req_i), .addr_i(inst_addr_i),
    .addr_ok_o(inst_addr_ok_o), .data_ok_o(inst_data_ok_o),
    .rdata_o(inst_rdata_o), .data_addr_o(inst_data_addr_o),
    .ar_valid_o(inst_ar_valid), .ar_o(inst_ar), .ar_ready_i(inst_ar_ready),
    .r_valid_i(inst_r_valid), .r_i, .r_ready_o(inst_r_ready)
  );

  axi_read_adapter u_data_rd (
    .aclk, .rst_i, .flush_i,
    .req_i(data_req_i & ~data_wr_i), .addr_i(data_addr_i),
    .addr_ok_o(rd_addr_ok), .data_ok_o(rd_data_ok),
    .rdata_o(data_rdata_o), .data_addr_o(),  // core tracks its own load address
    .ar_valid_o(data_ar_valid), .ar_o(data_ar), .ar_ready_i(data_ar_ready),
    .r_valid_i(data_r_valid), .r_i, .r_ready_o(data_r_ready)
  );

  axi_write_adapter u_wr (
    .aclk, .rst_i,
    .req_i(data_req_i & data_wr_i), .addr_i(data_addr_i),
    .wdata_i(data_wdata_i), .sel_i(data_sel_i), .done_o(wr_done),
    .aw_valid_o, .aw_o, .aw_ready_i, .w_valid_o, .w_o, .w_ready_i,
    .b_valid_i, .b_i, .b_ready_o
  );

  axi_read_arbiter u_rd_arb (
    .aclk, .rst_i,
    .data_ar_valid_i(data_ar_valid), .data_ar_i(data_ar), .data_ar_ready_o(data_ar_ready),
    .inst_ar_valid_i(inst_ar_valid), .inst_ar_i(inst_ar), .inst_ar_ready_o(inst_ar_ready),
    .data_r_valid_o(data_r_valid), .data_r_ready_i(data_r_ready),
    .inst_r_valid_o(inst_r_valid), .inst_r_ready_i(inst_r_ready),
    .ar_valid_o, .ar_o, .ar_ready_i, .r_valid_i, .r_i, .r_ready_o
  );

  // a write reports address and data ok together when its response is in
  assign data_addr_ok_o = rd_addr_ok | wr_done;
  assign data_data_ok_o = rd_data_ok | wr_done;

endmodule

/* verif/cpu_axi_bridge_checker.sv */
`timescale 1ns/1ps

module cpu_axi_bridge_checker
  import axi_bridge_pkg::*;
(
  input logic        aclk,
  input logic        rst_i,
  input logic        flush_i,
  input logic        ar_valid_o,
  input axi_ar_bus_t ar_o,
  input logic        ar_ready_i,
  input logic        r_ready_o,
  input logic        aw_valid_o,
  input axi_aw_t     aw_o,
  input logic        aw_ready_i,
  input logic        w_valid_o,
  input axi_w_t      w_o,
  input logic        w_ready_i,
  input logic        b_ready_o,
  input logic        inst_addr_ok_o,
  input logic        inst_data_ok_o,
  input logic        data_addr_ok_o,
  input logic        data_data_ok_o
);

  int unsigned fail_cnt = 0;  // number of failed assertions
  logic        flushed_q;     // set by a flush and cleared when the next fetch is accepted

  always_ff @(posedge aclk) begin
    if (rst_i) begin
      flushed_q <= 1'b0;
    end else begin
      flushed_q <= flush_i | (flushed_q & ~inst_addr_ok_o);
    end
  end

  // a stalled channel keeps valid and payload until the handshake
  ar_stable_a: assert property (@(posedge aclk) disable iff (rst_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else begin
      fail_cnt++;
      $error("AR changed while stalled");
    end
  aw_stable_a: assert property (@(posedge aclk) disable iff (rst_i)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else begin
      fail_cnt++;
      $error("AW changed while stalled");
    end
  w_stable_a: assert property (@(posedge aclk) disable iff (rst_i)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
    else begin
      fail_cnt++;
      $error("W changed while stalled");
    end

  reset_idle_a: assert property (@(posedge aclk)
    rst_i |=> !(ar_valid_o | aw_valid_o | w_valid_o | r_ready_o | b_ready_o |
                inst_addr_ok_o | inst_data_ok_o | data_addr_ok_o | data_data_ok_o))
    else begin
      fail_cnt++;
      $error("bus or ok outputs active after reset");
    end

  // the R beat of a flushed fetch must never show up as a data ok
  flush_drop_a: assert property (@(posedge aclk) disable iff (rst_i)
    flushed_q |-> !inst_data_ok_o)
    else begin
      fail_cnt++;
      $error("fetch data delivered after a flush");
    end

endmodule

/* verif/cpu_axi_bridge_tb.sv */
`timescale 1ns/1ps

module cpu_axi_bridge_tb
  import axi_bridge_pkg::*;
();

  logic aclk, rst_i, flush_i;
  logic inst_req_i, inst_addr_ok_o, inst_data_ok_o;
  addr_t inst_addr_i, inst_data_addr_o, data_addr_i;
  data_t inst_rdata_o, data_wdata_i, data_rdata_o;
  logic data_req_i, data_wr_i, data_addr_ok_o, data_data_ok_o;
  strb_t data_sel_i;
  logic ar_valid_o, ar_ready_i, r_valid_i, r_ready_o, aw_valid_o, aw_ready_i;
  logic w_valid_o, w_ready_i, b_valid_i, b_ready_o;
  axi_ar_bus_t ar_o;
  axi_r_t r_i;
  axi_aw_t aw_o;
  axi_w_t w_o;
  axi_b_t b_i;

  data_t slave_mem [addr_t];  // slave storage where unwritten words read as ~address
  data_t ref_mem [addr_t];    // expected memory contents
  axi_ar_bus_t rd_pend [$];   // accepted reads waiting for their R beat
  addr_t inst_exp [$];        // fetch addresses in request order
  int r_idx, cycles;
  logic have_aw, have_w, b_due;
  addr_t aw_addr, exp_a;
  axi_w_t w_q;
  data_t rd_word;

  cpu_axi_bridge u_cpu_axi_bridge (.*);
  bind cpu_axi_bridge cpu_axi_bridge_checker u_checker (.*);

  function automatic data_t merge_lanes(input data_t old, input data_t wd, input strb_t s);
    for (int i = 0; i < STRB_W; i++)
      if (s[i]) old[8*i +: 8] = wd[8*i +: 8];
    return old;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      report_failure($sformatf("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic issue_fetch(input addr_t a, input logic flush_after);
    @(posedge aclk);
    inst_req_i  <= 1'b1;
    inst_addr_i <= a;
    do @(negedge aclk); while (!inst_addr_ok_o);
    if (!flush_after) inst_exp.push_back(a);
    @(posedge aclk);
    inst_req_i <= 1'b0;
    flush_i    <= flush_after;  // lands while the fetch waits for R
    @(posedge aclk);
    flush_i <= 1'b0;
  endtask

  task automatic data_access(input logic wr, input addr_t a, input data_t wd, input strb_t s);
    @(posedge aclk);
    data_req_i   <= 1'b1;
    data_wr_i    <= wr;
    data_addr_i  <= a;
    data_wdata_i <= wd;
    data_sel_i   <= s;
    do @(negedge aclk); while (!data_addr_ok_o);
    @(posedge aclk);
    data_req_i <= 1'b0;
    if (wr) begin
      ref_mem[a] = merge_lanes(ref_mem.exists(a) ? ref_mem[a] : ~a, wd, s);
    end else begin
      do @(negedge aclk); while (!data_data_ok_o);
      check_value("data_rdata_o", data_rdata_o, ref_mem.exists(a) ? ref_mem[a] : ~a);
    end
  endtask

  task automatic fetch_stream(input int n);
    for (int i = 0; i < n; i++) issue_fetch(32'h1000 + ($urandom % 64) * 4, 1'b0);
  endtask

  task automatic data_stream(input int n);
    addr_t a;
    for (int i = 0; i < n; i++) begin
      a = 32'h2000 + ($urandom % 16) * 4;
      data_access(1'b1, a, $urandom, $urandom);
      data_access(1'b0, a, '0, '0);  // read back the merged word
    end
  endtask

  initial aclk = 1'b0;
  always #50 aclk = ~aclk;

  // AXI slave model where every ready and valid comes after a random wait
  always @(posedge aclk) begin
    ar_ready_i <= $urandom % 2;
    aw_ready_i <= $urandom % 2;
    w_ready_i  <= $urandom % 2;
    if (ar_valid_o && ar_ready_i) begin
      // one beat of four bytes with an INCR burst
      check_value("ar_o len/size/burst", {ar_o.len, ar_o.size, ar_o.burst}, 9'b0000_010_01);
      rd_pend.push_back(ar_o);
    end
    if (r_valid_i && r_ready_o) begin
      rd_pend.delete(r_idx);
      r_valid_i <= 1'b0;
    end else if (!r_valid_i && rd_pend.size() > 0 && ($urandom % 2)) begin
      r_idx = $urandom % rd_pend.size();  // either pending read may answer first
      rd_word = slave_mem.exists(rd_pend[r_idx].addr) ? slave_mem[rd_pend[r_idx].addr]
                                                      : ~rd_pend[r_idx].addr;
      r_i       <= '{id: rd_pend[r_idx].id, data: rd_word, resp: 2'b00, last: 1'b1};
      r_valid_i <= 1'b1;
    end
    if (aw_valid_o && aw_ready_i) begin
      check_value("aw_o len/size/burst", {aw_o.len, aw_o.size, aw_o.burst}, 9'b0000_010_01);
      aw_addr = aw_o.addr;
      have_aw = 1'b1;
    end
    if (w_valid_o && w_ready_i) begin
      check_value("w_o.last", w_o.last, 1'b1);
      w_q    = w_o;
      have_w = 1'b1;
    end
    if (have_aw && have_w) begin
      slave_mem[aw_addr] = merge_lanes(slave_mem.exists(aw_addr) ? slave_mem[aw_addr] : ~aw_addr,
                                       w_q.data, w_q.strb);
      have_aw = 1'b0;
      have_w  = 1'b0;
      b_due   = 1'b1;
    end
    if (b_valid_i && b_ready_o) begin
      b_valid_i <= 1'b0;
    end else if (b_due && ($urandom % 2)) begin
      b_valid_i <= 1'b1;
      b_due     = 1'b0;
    end
  end

  always @(negedge aclk) begin
    if (u_cpu_axi_bridge.u_checker.fail_cnt != 0) begin
      report_failure("an assertion in the bound checker failed");
    end else if (!rst_i && inst_data_ok_o) begin
      if (inst_exp.size() == 0) begin
        report_failure("inst_data_ok_o pulsed with no fetch pending");
      end else begin
        exp_a = inst_exp.pop_front();
        check_value("inst_data_addr_o", inst_data_addr_o, exp_a);
        check_value("inst_rdata_o", inst_rdata_o, ~exp_a);  // fetch region is never written
      end
    end
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles == 6000) report_failure("run did not finish within 6000 cycles");
  end

  initial begin
    void'($urandom(32'hb7a6_7cda));
    cycles = 0;
    rst_i = 1'b1;
    flush_i = 1'b0;
    inst_req_i = 1'b0;
    inst_addr_i = '0;
    data_req_i = 1'b0;
    data_wr_i = 1'b0;
    data_sel_i = '0;
    data_addr_i = '0;
    data_wdata_i = '0;
    ar_ready_i = 1'b0;
    r_valid_i = 1'b0;
    r_i = '0;
    aw_ready_i = 1'b0;
    w_ready_i = 1'b0;
    b_valid_i = 1'b0;
    b_i = '0;
    have_aw = 1'b0;
    have_w = 1'b0;
    b_due = 1'b0;
    repeat (2) @(posedge aclk);
    rst_i <= 1'b0;
    @(negedge aclk);
    check_value("bus valid/ready and ok outputs",
                {ar_valid_o, aw_valid_o, w_valid_o, r_ready_o, b_ready_o, inst_addr_ok_o,
                 inst_data_ok_o, data_addr_ok_o, data_data_ok_o}, '0);
    fork
      fetch_stream(140);
      data_stream(70);
    join
    for (int i = 0; i < 10; i++) begin
      issue_fetch(32'h1000 + ($urandom % 64) * 4, 1'b1);
      issue_fetch(32'h1000 + ($urandom % 64) * 4, 1'b0);
    end
    while (inst_exp.size() != 0) @(negedge aclk);
    repeat (4) @(negedge aclk);
    if (u_cpu_axi_bridge.u_checker.fail_cnt != 0) begin
      report_failure("an assertion in the bound checker failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* vlog.f */
hw/axi_bridge_pkg.sv
hw/axi_read_adapter.sv
hw/axi_write_adapter.sv
hw/axi_read_arbiter.sv
hw/cpu_axi_bridge.sv
verif/cpu_axi_bridge_checker.sv
verif/cpu_axi_bridge_tb.sv

/* Bender.yml */
package:
  name: cpu_axi_bridge

sources:
  - hw/axi_bridge_pkg.sv
  - hw/axi_read_adapter.sv
  - hw/axi_write_adapter.sv
  - hw/axi_read_arbiter.sv
  - hw/cpu_axi_bridge.sv
  - target: test
    files:
      - verif/cpu_axi_bridge_checker.sv
      - verif/cpu_axi_bridge_tb.sv
